//--- dv/usb_host_tasks.svh
// NRZI encoder state with J as the idle level
logic line_level;
int   ones_run;

// one bit time on the pair
task automatic hold_line(input logic dp, input logic dm);
    d_plus  = dp;
    d_minus = dm;
    repeat (CLKS_PER_BIT) begin
        @(posedge clk);
        #2;
    end
endtask

// zero toggles the line
task automatic put_bit(input logic value);
    if (!value) begin
        line_level = ~line_level;
    end
    hold_line(line_level, ~line_level);
    if (value) begin
        ones_run = ones_run + 1;
    end else begin
        ones_run = 0;
    end
    // six ones in a row get a stuffed zero
    if (ones_run == 6) begin
        line_level = ~line_level;
        hold_line(line_level, ~line_level);
        ones_run = 0;
    end
endtask

task automatic put_byte(input logic [7:0] value);
    int i;
    for (i = 0; i < 8; i++) begin
        put_bit(value[i]);
    end
endtask

task automatic send_packet(input logic [7:0] sync, input logic [3:0] pid);
    line_level = 1'b1;
    ones_run   = 0;
    put_byte(sync);
    put_byte({~pid, pid});
    foreach (tx_bytes[i]) begin
        put_byte(tx_bytes[i]);
    end
    // two bits of SE0 then back to J
    hold_line(1'b0, 1'b0);
    hold_line(1'b0, 1'b0);
    hold_line(1'b1, 1'b0);
endtask

task automatic bus_read(input logic [1:0] adr, output logic [31:0] data);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we  = 1'b0;
    wb_req.adr = adr;
    wb_req.dat = '0;
    do begin
        @(posedge clk);
        #2;
    end while (!wb_rsp.ack);
    data       = wb_rsp.dat;
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
endtask

//--- dv/tb_usb_rx.sv
`timescale 1ns/1ps
`default_nettype none

module tb_usb_rx;

    import usb_rx_pkg::*;

    localparam int         CLKS_PER_BIT   = 8;
    localparam logic [6:0] DEV_ADDR       = 7'h70;
    localparam logic [3:0] DEV_ENDP       = 4'h8;
    localparam int         FIFO_DEPTH     = 16;
    // 16 packets of at most ~25 line bytes at 64 clocks each plus reads
    localparam int         TIMEOUT_CYCLES = 40000;

    logic        clk = 1'b0;
    logic        n_rst;
    logic        d_plus;
    logic        d_minus;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    logic        pkt_done;

    integer      seed = 32'h115f_4ab5;
    int          cycle_count = 0;
    int          sent = 0;
    int          checked = 0;
    int          model_count = 0;
    logic        model_ovf = 1'b0;
    logic [31:0] exp_status_word = '0;
    logic [7:0]  tx_bytes [$];
    logic [7:0]  exp_fifo [$];

    usb_rx_top #(
        .CLKS_PER_BIT (CLKS_PER_BIT),
        .DEV_ADDR     (DEV_ADDR),
        .DEV_ENDP     (DEV_ENDP),
        .FIFO_DEPTH   (FIFO_DEPTH)
    ) UUT (
        .clk      (clk),
        .n_rst    (n_rst),
        .d_plus   (d_plus),
        .d_minus  (d_minus),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp),
        .pkt_done (pkt_done)
    );

    `include "usb_host_tasks.svh"

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("simulation timed out after %0d cycles", cycle_count);
            $display("Something failed");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("Something failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // status word as the register should show it after this packet
    function automatic logic [31:0] expect_status(
        input logic       sync_ok,
        input logic [3:0] pid,
        input logic [7:0] addr_byte,
        input logic [7:0] endp_byte,
        input int         payload_len,
        input int         fifo_cnt,
        input logic       fifo_ovf
    );
        rx_packet_t  kind;
        logic        err;
        logic        hit;
        int          cnt;
        logic        ovf;
        logic [31:0] word;
        kind = idle_packet;
        err  = 1'b0;
        hit  = 1'b0;
        cnt  = fifo_cnt;
        ovf  = fifo_ovf;
        if (!sync_ok) begin
            err = 1'b1;
        end else begin
            case (pid)
                PID_OUT, PID_IN: begin
                    kind = (pid == PID_OUT) ? out_tok : in_tok;
                    hit  = (addr_byte[6:0] == DEV_ADDR) &&
                           ({endp_byte[2:0], addr_byte[7]} == DEV_ENDP);
                end
                PID_DATA0, PID_DATA1: begin
                    kind = data_pkt;
                    // first stored byte restarts the FIFO
                    if (payload_len > 0) begin
                        cnt = (payload_len > FIFO_DEPTH) ? FIFO_DEPTH : payload_len;
                        ovf = (payload_len > FIFO_DEPTH);
                    end
                end
                PID_ACK: begin
                    kind = ack_hs;
                end
                PID_NAK: begin
                    kind = nak_hs;
                end
                default: begin
                    kind = error_pkt;
                    err  = 1'b1;
                end
            endcase
        end
        word       = '0;
        word[2:0]  = kind;
        word[3]    = err;
        word[4]    = hit;
        word[5]    = 1'b1;
        word[6]    = ovf;
        word[15:8] = 8'(cnt);
        return word;
    endfunction

    task automatic make_token(input logic [6:0] addr, input logic [3:0] endp);
        logic [31:0] rnd;
        rnd      = $random(seed);
        tx_bytes = {};
        // endpoint straddles both bytes and crc5 stays random
        tx_bytes.push_back({endp[0], addr});
        tx_bytes.push_back({rnd[4:0], endp[3:1]});
    endtask

    task automatic make_data(input int len);
        logic [31:0] rnd;
        int          i;
        tx_bytes = {};
        // payload then two crc16 bytes
        for (i = 0; i < len + 2; i++) begin
            rnd = $random(seed);
            tx_bytes.push_back(rnd[7:0]);
        end
    endtask

    task automatic run_packet(input logic [7:0] sync, input logic [3:0] pid);
        logic [7:0] addr_byte;
        logic [7:0] endp_byte;
        int         i;
        addr_byte = (tx_bytes.size() > 0) ? tx_bytes[0] : 8'h00;
        endp_byte = (tx_bytes.size() > 1) ? tx_bytes[1] : 8'h00;
        exp_status_word = expect_status(sync == SYNC_BYTE, pid, addr_byte, endp_byte,
                                        tx_bytes.size() - 2, model_count, model_ovf);
        model_count = int'(exp_status_word[15:8]);
        model_ovf   = exp_status_word[6];
        if (exp_status_word[2:0] == data_pkt && tx_bytes.size() > 2) begin
            exp_fifo = {};
            for (i = 0; i < model_count; i++) begin
                exp_fifo.push_back(tx_bytes[i]);
            end
        end
        sent = sent + 1;
        send_packet(sync, pid);
        while (checked != sent) begin
            @(posedge clk);
            #2;
        end
        repeat (2) hold_line(1'b1, 1'b0);
    endtask

    task automatic drain_fifo();
        logic [31:0] rd;
        logic [7:0]  want;
        while (exp_fifo.size() > 0) begin
            want = exp_fifo.pop_front();
            bus_read(REG_DATA, rd);
            check_value("wb_rsp.dat (fifo data)", rd, {24'h0, want});
        end
        bus_read(REG_DATA, rd);
        check_value("wb_rsp.dat (empty fifo)", rd, 32'h0);
        model_count = 0;
    endtask

    // status check on every finished packet
    initial begin : compare_status
        logic [31:0] rd;
        forever begin
            @(posedge clk);
            #2;
            if (pkt_done) begin
                bus_read(REG_STATUS, rd);
                check_value("wb_rsp.dat (status)", rd, exp_status_word);
                checked = checked + 1;
            end
        end
    end

    initial begin : stimulus
        logic [31:0] rnd;
        int          k;
        n_rst      = 1'b0;
        d_plus     = 1'b1;
        d_minus    = 1'b0;
        wb_req     = '0;
        line_level = 1'b1;
        ones_run   = 0;
        repeat (10) @(posedge clk);
        #2;
        n_rst = 1'b1;
        repeat (4) hold_line(1'b1, 1'b0);

        // tokens for this device and for others
        make_token(DEV_ADDR, DEV_ENDP);
        run_packet(SYNC_BYTE, PID_OUT);
        make_token(DEV_ADDR, DEV_ENDP);
        run_packet(SYNC_BYTE, PID_IN);
        make_token(7'h15, DEV_ENDP);
        run_packet(SYNC_BYTE, PID_OUT);
        make_token(DEV_ADDR, 4'h3);
        run_packet(SYNC_BYTE, PID_IN);

        for (k = 0; k < 4; k++) begin
            rnd = $random(seed);
            make_data(1 + int'(rnd % 32'd12));
            run_packet(SYNC_BYTE, k[0] ? PID_DATA1 : PID_DATA0);
            drain_fifo();
        end

        tx_bytes = {};
        run_packet(SYNC_BYTE, PID_ACK);
        run_packet(SYNC_BYTE, PID_NAK);

        // bad sync, unknown pid, then a clean packet
        make_token(DEV_ADDR, DEV_ENDP);
        run_packet(8'hC0, PID_OUT);
        tx_bytes = {};
        run_packet(SYNC_BYTE, 4'b1100);
        make_data(3);
        run_packet(SYNC_BYTE, PID_DATA0);
        drain_fifo();

        // all ones forces stuffing
        tx_bytes = {};
        repeat (8) tx_bytes.push_back(8'hFF);
        run_packet(SYNC_BYTE, PID_DATA1);
        drain_fifo();

        make_data(FIFO_DEPTH + 3);
        run_packet(SYNC_BYTE, PID_DATA0);
        drain_fifo();
        make_data(2);
        run_packet(SYNC_BYTE, PID_DATA1);
        drain_fifo();

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --timescale 1ns/1ps \
    --top-module tb_usb_rx \
    -f vlog.f \
    -o sim_usb_rx

./obj_dir/sim_usb_rx

//--- verilog/rcu.sv
`timescale 1ns/1ps
`default_nettype none

module rcu #(
    parameter logic [6:0] DEV_ADDR = 7'h70,
    parameter logic [3:0] DEV_ENDP = 4'h8
) (
    input  wire                    clk,
    input  wire                    n_rst,
    input  wire                    shift_enable,
    input  wire                    eop,
    input  wire                    edge_start,
    input  wire                    one_byte,
    input  wire  [7:0]             rcv_data,
    output logic                   store_rx_packet,
    output logic                   w_enable_buffer,
    output logic [7:0]             wdata,
    output logic                   receiving,
    output logic                   r_error,
    output logic                   timer_clear,
    output logic                   packet_done,
    output usb_rx_pkg::rx_status_t status
);

    import usb_rx_pkg::*;

    typedef enum logic [3:0] {
        idle,
        load_sync,
        load_pid,
        data_state,
        token,
        token_number,
        error_state,
        wait_eop,
        transfer_done
    } state_t;

    state_t     state;
    state_t     next_state;
    rx_status_t next_status;
    logic       endp_lsb;
    logic       next_endp_lsb;
    logic       bit_pending;
    logic       first_wr;
    logic [1:0] hold_cnt;
    logic [7:0] hold_a;
    logic [7:0] hold_b;

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            state       <= idle;
            status      <= '0;
            endp_lsb    <= 1'b0;
            packet_done <= 1'b0;
            bit_pending <= 1'b0;
            first_wr    <= 1'b1;
            hold_cnt    <= '0;
        end else begin
            state       <= next_state;
            status      <= next_status;
            endp_lsb    <= next_endp_lsb;
            packet_done <= (next_state == transfer_done) && (state != transfer_done);

            if (one_byte || edge_start) begin
                bit_pending <= 1'b0;
            end else if (shift_enable) begin
                bit_pending <= 1'b1;
            end

            if (state != data_state) begin
                hold_cnt <= '0;
                first_wr <= 1'b1;
            end else if (one_byte) begin
                if (hold_cnt != 2'd2) begin
                    hold_cnt <= hold_cnt + 1'b1;
                end
                if (w_enable_buffer) begin
                    first_wr <= 1'b0;
                end
            end
        end
    end

    // writes trail by two since the last two data bytes are CRC16
    always_ff @(posedge clk) begin
        if (state == data_state && one_byte) begin
            hold_a <= hold_b;
            hold_b <= rcv_data;
        end
    end

    always_comb begin
        next_state    = state;
        next_status   = status;
        next_endp_lsb = endp_lsb;
        case (state)
            load_sync: begin
                if (one_byte) begin
                    if (rcv_data == SYNC_BYTE) begin
                        next_state = load_pid;
                    end else begin
                        next_state        = error_state;
                        next_status.error = 1'b1;
                    end
                end
            end

            load_pid: begin
                if (one_byte) begin
                    case (rcv_data[3:0])
                        PID_OUT: begin
                            next_state       = token;
                            next_status.kind = out_tok;
                        end
                        PID_IN: begin
                            next_state       = token;
                            next_status.kind = in_tok;
                        end
                        PID_DATA0, PID_DATA1: begin
                            next_state       = data_state;
                            next_status.kind = data_pkt;
                        end
                        PID_ACK: begin
                            next_state       = wait_eop;
                            next_status.kind = ack_hs;
                        end
                        PID_NAK: begin
                            next_state       = wait_eop;
                            next_status.kind = nak_hs;
                        end
                        default: begin
                            next_state        = error_state;
                            next_status.kind  = error_pkt;
                            next_status.error = 1'b1;
                        end
                    endcase
                end
            end

            token: begin
                if (one_byte) begin
                    if (rcv_data[6:0] == DEV_ADDR) begin
                        next_endp_lsb = rcv_data[7];
                        next_state    = token_number;
                    end else begin
                        // not ours so let it run out
                        next_state = wait_eop;
                    end
                end
            end

            token_number: begin
                if (one_byte) begin
                    if ({rcv_data[2:0], endp_lsb} == DEV_ENDP) begin
                        next_status.token_hit = 1'b1;
                    end
                    next_state = wait_eop;
                end
            end

            data_state: begin
                if (eop) begin
                    // leftover bits mean a torn last byte
                    next_state        = transfer_done;
                    next_status.error = bit_pending;
                end
            end

            error_state, wait_eop: begin
                if (eop) begin
                    next_state = transfer_done;
                end
            end

            default: begin
                if (edge_start) begin
                    next_state  = load_sync;
                    next_status = '0;
                end
            end
        endcase

        // packet cut short before the header was complete
        if (eop && (state inside {load_sync, load_pid, token, token_number})) begin
            next_state        = transfer_done;
            next_status.error = 1'b1;
        end

        if (next_state == transfer_done) begin
            next_status.done = 1'b1;
        end
    end

    assign receiving = state inside {load_sync, load_pid, token, token_number,
                                     data_state, wait_eop};
    assign r_error         = (state == error_state);
    assign timer_clear     = (state == transfer_done);
    assign w_enable_buffer = (state == data_state) && one_byte && (hold_cnt == 2'd2);
    assign store_rx_packet = w_enable_buffer && first_wr;
    assign wdata           = hold_a;

endmodule

`default_nettype wire

//--- verilog/rx_byte_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module rx_byte_shifter (
    input  wire        clk,
    input  wire        n_rst,
    input  wire        shift_enable,
    input  wire        rx_bit,
    input  wire        eop,
    input  wire        timer_clear,
    output logic [7:0] rcv_data,
    output logic       one_byte
);

    logic [2:0] bit_cnt;

    // LSB first on the wire, so fill from the top
    always_ff @(posedge clk) begin
        if (shift_enable) begin
            rcv_data <= {rx_bit, rcv_data[7:1]};
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            bit_cnt  <= '0;
            one_byte <= 1'b0;
        end else begin
            one_byte <= shift_enable && (bit_cnt == 3'd7);
            if (timer_clear || eop) begin
                bit_cnt <= '0;
            end else if (shift_enable) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/rx_fifo_wb.sv
`timescale 1ns/1ps
`default_nettype none

module rx_fifo_wb #(
    parameter int FIFO_DEPTH = 16
) (
    input  wire                    clk,
    input  wire                    n_rst,
    input  wire                    w_enable_buffer,
    input  wire                    store_rx_packet,
    input  wire  [7:0]             wdata,
    input  wire usb_rx_pkg::rx_status_t status,
    input  wire usb_rx_pkg::wb_req_t    wb_req,
    output usb_rx_pkg::wb_rsp_t    wb_rsp
);

    import usb_rx_pkg::*;

    localparam int AW = $clog2(FIFO_DEPTH);
    localparam logic [AW-1:0] LAST_PTR = AW'(FIFO_DEPTH - 1);
    localparam logic [AW:0]   FULL_CNT = (AW + 1)'(FIFO_DEPTH);

    logic [7:0]    mem [FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          overflow;
    logic          full;
    logic          empty;
    logic          push;
    logic          pop;
    logic          req;
    logic          ack_q;
    logic [31:0]   dat_q;
    logic [31:0]   status_word;
    logic [31:0]   data_word;

    assign full  = (count == FULL_CNT);
    assign empty = (count == '0);
    assign push  = w_enable_buffer && !store_rx_packet && !full;

    assign req = wb_req.cyc && wb_req.stb;
    assign pop = req && !ack_q && !wb_req.we && (wb_req.adr == REG_DATA) && !empty;

    always_ff @(posedge clk) begin
        if (store_rx_packet) begin
            mem[0] <= wdata;
        end else if (push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else if (store_rx_packet) begin
            // new packet restarts the buffer
            wr_ptr   <= AW'(1);
            rd_ptr   <= '0;
            count    <= (AW + 1)'(1);
            overflow <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
            if (w_enable_buffer && full) begin
                overflow <= 1'b1;
            end
        end
    end

    always_comb begin
        status_word          = '0;
        status_word[2:0]     = status.kind;
        status_word[3]       = status.error;
        status_word[4]       = status.token_hit;
        status_word[5]       = status.done;
        status_word[6]       = overflow;
        status_word[8 +: AW + 1] = count;
    end

    assign data_word = empty ? 32'h0 : {24'h0, mem[rd_ptr]};

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req && !ack_q;
        end
    end

    always_ff @(posedge clk) begin
        if (req && !ack_q) begin
            dat_q <= (wb_req.adr == REG_DATA) ? data_word : status_word;
        end
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = dat_q;

endmodule

`default_nettype wire

//--- verilog/usb_rx_phy.sv
`timescale 1ns/1ps
`default_nettype none

module usb_rx_phy #(
    parameter int CLKS_PER_BIT = 8
) (
    input  wire  clk,
    input  wire  n_rst,
    input  wire  d_plus,
    input  wire  d_minus,
    input  wire  receiving,
    output logic shift_enable,
    output logic rx_bit,
    output logic edge_start,
    output logic eop
);

    localparam int CW = $clog2(CLKS_PER_BIT);
    localparam logic [CW-1:0] MID_CNT  = CW'(CLKS_PER_BIT / 2);
    localparam logic [CW-1:0] LAST_CNT = CW'(CLKS_PER_BIT - 1);

    logic [1:0]    dp_sync;
    logic [1:0]    dm_sync;
    logic          dp_prev;
    logic          dm_prev;
    logic          busy;
    logic          last_dp;
    logic          line_edge;
    logic          sample;
    logic          bit_val;
    logic [CW-1:0] bit_cnt;
    logic [2:0]    ones;

    // any change on the pair resyncs the bit timer
    assign line_edge = (dp_sync[1] != dp_prev) || (dm_sync[1] != dm_prev);

    // J to K while the line is idle
    assign edge_start = !busy && !receiving && dp_prev && !dp_sync[1];

    assign sample = busy && (bit_cnt == MID_CNT);

    // NRZI where no change means a one
    assign bit_val = (dp_sync[1] == last_dp);

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            dp_sync      <= 2'b11;
            dm_sync      <= 2'b00;
            dp_prev      <= 1'b1;
            dm_prev      <= 1'b0;
            busy         <= 1'b0;
            last_dp      <= 1'b1;
            bit_cnt      <= '0;
            ones         <= '0;
            shift_enable <= 1'b0;
            rx_bit       <= 1'b0;
            eop          <= 1'b0;
        end else begin
            dp_sync      <= {dp_sync[0], d_plus};
            dm_sync      <= {dm_sync[0], d_minus};
            dp_prev      <= dp_sync[1];
            dm_prev      <= dm_sync[1];
            shift_enable <= 1'b0;
            eop          <= 1'b0;

            if (line_edge || bit_cnt == LAST_CNT) begin
                bit_cnt <= '0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end

            if (edge_start) begin
                busy    <= 1'b1;
                last_dp <= 1'b1;
                ones    <= '0;
            end

            if (sample) begin
                if (!dp_sync[1] && !dm_sync[1]) begin
                    // SE0 ends the packet
                    eop  <= 1'b1;
                    busy <= 1'b0;
                end else begin
                    last_dp <= dp_sync[1];
                    if (ones == 3'd6) begin
                        // drop the stuffed zero
                        ones <= '0;
                    end else begin
                        shift_enable <= 1'b1;
                        rx_bit       <= bit_val;
                        ones         <= bit_val ? ones + 1'b1 : 3'd0;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/usb_rx_pkg.sv
`default_nettype none

package usb_rx_pkg;

    typedef enum logic [2:0] {
        idle_packet = 3'd0,
        in_tok      = 3'd1,
        out_tok     = 3'd2,
        data_pkt    = 3'd3,
        ack_hs      = 3'd4,
        nak_hs      = 3'd5,
        error_pkt   = 3'd6
    } rx_packet_t;

    // outcome of the last received packet
    typedef struct packed {
        rx_packet_t kind;
        logic       error;
        logic       token_hit;
        logic       done;
    } rx_status_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [1:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // KJKJKJKK with the last bit landing in bit 7
    localparam logic [7:0] SYNC_BYTE = 8'h80;

    localparam logic [3:0] PID_OUT   = 4'b0001;
    localparam logic [3:0] PID_IN    = 4'b1001;
    localparam logic [3:0] PID_DATA0 = 4'b0011;
    localparam logic [3:0] PID_DATA1 = 4'b1011;
    localparam logic [3:0] PID_ACK   = 4'b0010;
    localparam logic [3:0] PID_NAK   = 4'b1010;

    localparam logic [1:0] REG_STATUS = 2'd0;
    localparam logic [1:0] REG_DATA   = 2'd1;

endpackage

`default_nettype wire

//--- verilog/usb_rx_top.sv
`timescale 1ns/1ps
`default_nettype none

module usb_rx_top #(
    parameter int         CLKS_PER_BIT = 8,
    parameter logic [6:0] DEV_ADDR     = 7'h70,
    parameter logic [3:0] DEV_ENDP     = 4'h8,
    parameter int         FIFO_DEPTH   = 16
) (
    input  wire                 clk,
    input  wire                 n_rst,
    input  wire                 d_plus,
    input  wire                 d_minus,
    input  wire usb_rx_pkg::wb_req_t wb_req,
    output usb_rx_pkg::wb_rsp_t wb_rsp,
    output logic                pkt_done
);

    import usb_rx_pkg::*;

    logic       shift_enable;
    logic       rx_bit;
    logic       edge_start;
    logic       eop;
    logic       receiving;
    logic       timer_clear;
    logic       one_byte;
    logic [7:0] rcv_data;
    logic       w_enable_buffer;
    logic       store_rx_packet;
    logic [7:0] wdata;
    rx_status_t status;

    usb_rx_phy #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_phy (
        .clk          (clk),
        .n_rst        (n_rst),
        .d_plus       (d_plus),
        .d_minus      (d_minus),
        .receiving    (receiving),
        .shift_enable (shift_enable),
        .rx_bit       (rx_bit),
        .edge_start   (edge_start),
        .eop          (eop)
    );

    rx_byte_shifter u_shifter (
        .clk          (clk),
        .n_rst        (n_rst),
        .shift_enable (shift_enable),
        .rx_bit       (rx_bit),
        .eop          (eop),
        .timer_clear  (timer_clear),
        .rcv_data     (rcv_data),
        .one_byte     (one_byte)
    );

    rcu #(
        .DEV_ADDR (DEV_ADDR),
        .DEV_ENDP (DEV_ENDP)
    ) u_rcu (
        .clk             (clk),
        .n_rst           (n_rst),
        .shift_enable    (shift_enable),
        .eop             (eop),
        .edge_start      (edge_start),
        .one_byte        (one_byte),
        .rcv_data        (rcv_data),
        .store_rx_packet (store_rx_packet),
        .w_enable_buffer (w_enable_buffer),
        .wdata           (wdata),
        .receiving       (receiving),
        .r_error         (),
        .timer_clear     (timer_clear),
        .packet_done     (pkt_done),
        .status          (status)
    );

    rx_fifo_wb #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk             (clk),
        .n_rst           (n_rst),
        .w_enable_buffer (w_enable_buffer),
        .store_rx_packet (store_rx_packet),
        .wdata           (wdata),
        .status          (status),
        .wb_req          (wb_req),
        .wb_rsp          (wb_rsp)
    );

endmodule

`default_nettype wire

//--- vlog.f
+incdir+dv
verilog/usb_rx_pkg.sv
verilog/usb_rx_phy.sv
verilog/rx_byte_shifter.sv
verilog/rcu.sv
verilog/rx_fifo_wb.sv
verilog/usb_rx_top.sv
dv/tb_usb_rx.sv
